//--- build.f
+incdir+source
source/otp_types_pkg.sv
source/otp_lc_pkg.sv
source/otp_if.sv
source/otp_lci.sv
source/otp_dai.sv
source/otp_arb.sv
source/otp_macro.sv
source/otp_lc_top.sv
verification/otp_lc_props.sv
verification/otp_lc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the OTP life-cycle testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module otp_lc_tb -Mdir "$obj_dir" -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Property failures are counted by the testbench, so keep running after one
"./$obj_dir/Votp_lc_tb" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log_file"; then
  echo "No final result found in $log_file"
  exit 1
fi
exit 0

//--- source/otp_arb.sv
`default_nettype none
`timescale 1ns/1ps

module otp_arb (
  input  logic     clk_i,
  input  logic     rst_ni,
  otp_if.responder lci,
  otp_if.responder dai,
  otp_if.requester mac
);
  import otp_types_pkg::*;

  logic busy_q;
  // Owner of the current transaction, 1 for the DAI
  // Also the last winner for round-robin
  logic owner_q;
  logic pick_dai;

  // Last winner loses a tie
  assign pick_dai = dai.req && (!lci.req || !owner_q);

  ////////////////////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////////////////////

  // Nothing is forwarded while a transaction is open
  assign mac.req   = !busy_q && (lci.req || dai.req);
  assign mac.cmd   = pick_dai ? dai.cmd   : lci.cmd;
  assign mac.addr  = pick_dai ? dai.addr  : lci.addr;
  assign mac.wdata = pick_dai ? dai.wdata : lci.wdata;

  assign lci.gnt = mac.gnt && !pick_dai;
  assign dai.gnt = mac.gnt &&  pick_dai;

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////

  assign lci.rvalid = mac.rvalid && busy_q && !owner_q;
  assign dai.rvalid = mac.rvalid && busy_q &&  owner_q;
  assign lci.rdata  = owner_q ? '0 : mac.rdata;
  assign dai.rdata  = owner_q ? mac.rdata : '0;
  assign lci.err    = owner_q ? no_error : mac.err;
  assign dai.err    = owner_q ? mac.err : no_error;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (mac.gnt) begin
      busy_q  <= 1'b1;
      owner_q <= pick_dai;
    end else if (mac.rvalid) begin
      busy_q  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/otp_cfg.svh
`ifndef OTP_CFG_SVH
`define OTP_CFG_SVH

// Fuse word width in bits
`define OTP_WORD_W 16

// Number of fuse words in the array
`define OTP_DEPTH 32

// First word of the life-cycle partition
`define LC_OFFSET 24

// Number of words in the life-cycle partition
`define LC_WORDS 4

`endif

//--- source/otp_dai.sv
`default_nettype none
`timescale 1ns/1ps

`include "otp_cfg.svh"

module otp_dai (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Wishbone classic slave
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  otp_types_pkg::otp_addr_t wb_adr_i,
  input  otp_types_pkg::otp_word_t wb_dat_i,
  output otp_types_pkg::otp_word_t wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  otp_if.requester                 otp
);
  import otp_types_pkg::*;

  typedef enum logic [1:0] {
    dai_idle_st,
    dai_req_st,
    dai_wait_st,
    dai_done_st
  } dai_state_e;

  dai_state_e state_d, state_q;
  logic       wb_start, lc_hit;
  logic       ack_d, ack_q, err_d, err_q;
  otp_word_t  dat_q;

  // Bus cycle open
  assign wb_start = wb_cyc_i & wb_stb_i;

  // Address falls inside the life-cycle partition
  assign lc_hit = (wb_adr_i >= otp_addr_t'(`LC_OFFSET)) &&
                  (wb_adr_i <  otp_addr_t'(`LC_OFFSET + `LC_WORDS));

  // Master keeps address and data stable for the whole cycle
  assign otp.cmd   = wb_we_i ? cmd_write : cmd_read;
  assign otp.addr  = wb_adr_i;
  assign otp.wdata = wb_dat_i;

  ////////////////////////////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    err_d   = 1'b0;
    otp.req = 1'b0;

    unique case (state_q)
      dai_idle_st: begin
        if (wb_start) begin
          // Protected program is refused without a fuse access
          if (wb_we_i && lc_hit) begin
            err_d   = 1'b1;
            state_d = dai_done_st;
          end else begin
            state_d = dai_req_st;
          end
        end
      end
      dai_req_st: begin
        otp.req = 1'b1;
        if (otp.gnt) begin
          state_d = dai_wait_st;
        end
      end
      dai_wait_st: begin
        if (otp.rvalid) begin
          state_d = dai_done_st;
          if (otp.err != no_error) begin
            err_d = 1'b1;
          end else begin
            ack_d = 1'b1;
          end
        end
      end
      // Ack cycle, strobe is still high here
      dai_done_st: begin
        state_d = dai_idle_st;
      end
      default: begin
        state_d = dai_idle_st;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dai_idle_st;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
      err_q   <= err_d;
    end
  end

  // Read data held for the ack cycle
  always_ff @(posedge clk_i) begin
    if (state_q == dai_wait_st && otp.rvalid) begin
      dat_q <= otp.rdata;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

endmodule

`default_nettype wire

//--- source/otp_if.sv
`default_nettype none
`timescale 1ns/1ps

interface otp_if;
  import otp_types_pkg::*;

  // Request side
  logic      req;
  otp_cmd_e  cmd;
  otp_addr_t addr;
  otp_word_t wdata;

  // Response side
  logic      gnt;
  logic      rvalid;
  otp_word_t rdata;
  otp_err_e  err;

  // Issues commands and waits for the response
  modport requester (
    output req, cmd, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  // Grants commands and returns one response per grant
  modport responder (
    input  req, cmd, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

//--- source/otp_lc_pkg.sv
`default_nettype none

`include "otp_cfg.svh"

package otp_lc_pkg;

  // Full partition image, word 0 in the low bits
  typedef logic [`LC_WORDS*`OTP_WORD_W-1:0] lc_image_t;

  // Word counter across the partition
  typedef logic [$clog2(`LC_WORDS)-1:0] lc_cnt_t;

  // Life-cycle controller states
  typedef enum logic [2:0] {
    reset_st,
    idle_st,
    write_st,
    write_wait_st,
    error_st
  } lci_state_e;

endpackage

`default_nettype wire

//--- source/otp_lc_top.sv
`default_nettype none
`timescale 1ns/1ps

module otp_lc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Host bus
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  otp_types_pkg::otp_addr_t wb_adr_i,
  input  otp_types_pkg::otp_word_t wb_dat_i,
  output otp_types_pkg::otp_word_t wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  // Life-cycle port
  input  logic                     lci_en_i,
  input  logic                     escalate_i,
  input  logic                     lc_req_i,
  input  otp_lc_pkg::lc_image_t    lc_data_i,
  output logic                     lc_ack_o,
  output logic                     lc_err_o,
  output otp_types_pkg::otp_err_e  lci_error_o,
  output logic                     lci_idle_o
);

  // Requester links into the arbiter and its link to the array
  otp_if lci_if ();
  otp_if dai_if ();
  otp_if mac_if ();

  otp_lci u_lci (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lci_en_i   (lci_en_i),
    .escalate_i (escalate_i),
    .lc_req_i   (lc_req_i),
    .lc_data_i  (lc_data_i),
    .lc_ack_o   (lc_ack_o),
    .lc_err_o   (lc_err_o),
    .error_o    (lci_error_o),
    .idle_o     (lci_idle_o),
    .otp        (lci_if.requester)
  );

  otp_dai u_dai (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .otp      (dai_if.requester)
  );

  otp_arb u_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .lci    (lci_if.responder),
    .dai    (dai_if.responder),
    .mac    (mac_if.requester)
  );

  otp_macro u_macro (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .otp    (mac_if.responder)
  );

endmodule

`default_nettype wire

//--- source/otp_lci.sv
`default_nettype none
`timescale 1ns/1ps

`include "otp_cfg.svh"

module otp_lci (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lci_en_i,
  // Level escalation, forces the terminal state
  input  logic                    escalate_i,
  // Transition request with the full partition image
  input  logic                    lc_req_i,
  input  otp_lc_pkg::lc_image_t   lc_data_i,
  output logic                    lc_ack_o,
  output logic                    lc_err_o,
  output otp_types_pkg::otp_err_e error_o,
  output logic                    idle_o,
  otp_if.requester                otp
);
  import otp_types_pkg::*;
  import otp_lc_pkg::*;

  localparam lc_cnt_t last_cnt = lc_cnt_t'(`LC_WORDS - 1);

  lci_state_e state_d, state_q;
  lc_cnt_t    cnt_q;
  logic       cnt_clr, cnt_en;
  otp_err_e   error_d, error_q;
  otp_word_t  [`LC_WORDS-1:0] image_words;

  ////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    error_d  = error_q;
    cnt_clr  = 1'b0;
    cnt_en   = 1'b0;
    idle_o   = 1'b1;
    lc_ack_o = 1'b0;
    lc_err_o = 1'b0;
    otp.req  = 1'b0;
    otp.cmd  = cmd_read;

    unique case (state_q)
      // Hold here until the controller is enabled
      reset_st: begin
        idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = idle_st;
        end
      end
      // Start a transition from word 0
      idle_st: begin
        if (lc_req_i) begin
          state_d = write_st;
          cnt_clr = 1'b1;
        end
      end
      // Program the current word
      write_st: begin
        idle_o  = 1'b0;
        otp.req = 1'b1;
        otp.cmd = cmd_write;
        if (otp.gnt) begin
          state_d = write_wait_st;
        end
      end
      // Wait for the word's response
      write_wait_st: begin
        idle_o = 1'b0;
        if (otp.rvalid) begin
          // Only the first failing word sets the code
          // Remaining words are still programmed
          if (otp.err != no_error && error_q == no_error) begin
            error_d = otp.err;
          end
          if (cnt_q == last_cnt) begin
            lc_ack_o = 1'b1;
            state_d  = idle_st;
            if (error_d != no_error) begin
              lc_err_o = 1'b1;
              state_d  = error_st;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = write_st;
          end
        end
      end
      // Terminal state, no further acks
      error_st: begin
        if (error_q == no_error) begin
          error_d = fsm_state_error;
        end
      end
      // Invalid encoding
      default: begin
        state_d = error_st;
        error_d = fsm_state_error;
      end
    endcase

    // Escalation overrides everything
    if (escalate_i) begin
      state_d = error_st;
      if (error_q == no_error) begin
        error_d = fsm_state_error;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data
  ////////////////////////////////////////////////////////////////////////////

  assign image_words = lc_data_i;

  // Partition offset plus word count
  assign otp.addr  = otp_addr_t'(`LC_OFFSET) + otp_addr_t'(cnt_q);
  assign otp.wdata = image_words[cnt_q];

  assign error_o = error_q;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= reset_st;
      error_q <= no_error;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/otp_macro.sv
`default_nettype none
`timescale 1ns/1ps

`include "otp_cfg.svh"

module otp_macro (
  input  logic     clk_i,
  input  logic     rst_ni,
  otp_if.responder otp
);
  import otp_types_pkg::*;

  otp_word_t mem_q [`OTP_DEPTH];
  otp_word_t cur_word;
  logic      is_prog, blank_fail, prog_en;

  // Response pipeline
  logic      valid1_q, valid2_q;
  otp_word_t rdata1_q, rdata2_q;
  otp_err_e  err1_q, err2_q;

  // Always ready
  assign otp.gnt = otp.req;

  assign cur_word = mem_q[otp.addr];
  assign is_prog  = otp.cmd == cmd_write;

  // A set bit may never return to zero
  assign blank_fail = is_prog && ((cur_word & ~otp.wdata) != '0);
  assign prog_en    = otp.gnt && is_prog && !blank_fail;

  ////////////////////////////////////////////////////////////////////////////
  // Fuse storage
  ////////////////////////////////////////////////////////////////////////////

  // Blank array after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (prog_en) begin
      mem_q[otp.addr] <= otp.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Two-stage response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
    end else begin
      valid1_q <= otp.gnt;
      valid2_q <= valid1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata1_q <= cur_word;
    err1_q   <= blank_fail ? write_blank_error : no_error;
    rdata2_q <= rdata1_q;
    err2_q   <= err1_q;
  end

  assign otp.rvalid = valid2_q;
  assign otp.rdata  = rdata2_q;
  assign otp.err    = err2_q;

endmodule

`default_nettype wire

//--- source/otp_types_pkg.sv
`default_nettype none

`include "otp_cfg.svh"

package otp_types_pkg;

  // Address width follows from the array depth
  localparam int otp_addr_w = $clog2(`OTP_DEPTH);

  // One native fuse word
  typedef logic [`OTP_WORD_W-1:0] otp_word_t;

  // Fuse word address
  typedef logic [otp_addr_w-1:0] otp_addr_t;

  // Command on the OTP port
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } otp_cmd_e;

  // Error codes returned by the array and latched by the controllers
  typedef enum logic [1:0] {
    no_error          = 2'd0,
    write_blank_error = 2'd1,
    access_error      = 2'd2,
    fsm_state_error   = 2'd3
  } otp_err_e;

endpackage

`default_nettype wire

//--- verification/otp_lc_props.sv
`default_nettype none
`timescale 1ns/1ps

`include "otp_cfg.svh"

module otp_lc_props (
  input logic                     clk_i,
  input logic                     rst_ni,
  // Command port under watch
  input logic                     req_i,
  input otp_types_pkg::otp_cmd_e  cmd_i,
  input otp_types_pkg::otp_addr_t addr_i,
  input otp_types_pkg::otp_word_t wdata_i,
  input logic                     gnt_i,
  input logic                     rvalid_i,
  input logic                     busy_i,
  // Life-cycle acknowledge and where it may appear
  input logic                     lc_ack_i,
  input logic                     ack_allowed_i
);
  import otp_lc_pkg::*;

  localparam lc_cnt_t last_resp = lc_cnt_t'(`LC_WORDS - 1);

  // Read by the testbench at the end of the run
  int      fail_cnt = 0;
  logic    pending_q;
  // Responses seen since the last acknowledge
  lc_cnt_t resp_cnt_q;

  // One grant opens a response slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (gnt_i) begin
      pending_q <= 1'b1;
    end else if (rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  // Word responses within one transition
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_cnt_q <= '0;
    end else if (lc_ack_i) begin
      resp_cnt_q <= '0;
    end else if (rvalid_i) begin
      resp_cnt_q <= resp_cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Port rules
  //////////////////////////////////////////////////////////////////////////

  one_rvalid_per_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> pending_q) else begin
    $error("Response without an open grant");
    fail_cnt++;
  end

  no_gnt_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_i |-> !gnt_i) else begin
    $error("Grant during an open transaction");
    fail_cnt++;
  end

  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable({cmd_i, addr_i, wdata_i})) else begin
    $error("Request dropped or changed before its grant");
    fail_cnt++;
  end

  // Acknowledge only in write wait, with the last word's response
  ack_in_write_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_i |-> ack_allowed_i && rvalid_i && resp_cnt_q == last_resp) else begin
    $error("Life-cycle ack outside the last word response in write wait");
    fail_cnt++;
  end

endmodule

// Arbiter side, on the host requester port
bind otp_arb otp_lc_props arb_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_i         (dai.req),
  .cmd_i         (dai.cmd),
  .addr_i        (dai.addr),
  .wdata_i       (dai.wdata),
  .gnt_i         (dai.gnt),
  .rvalid_i      (dai.rvalid),
  .busy_i        (busy_q),
  .lc_ack_i      (1'b0),
  .ack_allowed_i (1'b1)
);

// Life-cycle controller side
bind otp_lci otp_lc_props lci_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_i         (otp.req),
  .cmd_i         (otp.cmd),
  .addr_i        (otp.addr),
  .wdata_i       (otp.wdata),
  .gnt_i         (otp.gnt),
  .rvalid_i      (otp.rvalid),
  .busy_i        (state_q == otp_lc_pkg::write_wait_st),
  .lc_ack_i      (lc_ack_o),
  .ack_allowed_i (state_q == otp_lc_pkg::write_wait_st)
);

`default_nettype wire

//--- verification/otp_lc_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "otp_cfg.svh"

module otp_lc_tb;
  import otp_types_pkg::*;
  import otp_lc_pkg::*;

  // Roughly 200 operations at 30 cycles each, with margin
  localparam int        timeout_cycles = 20000;
  localparam otp_addr_t lc_first       = otp_addr_t'(`LC_OFFSET);

  logic      clk_i;
  logic      rst_ni;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  otp_addr_t wb_adr_i;
  otp_word_t wb_dat_i;
  otp_word_t wb_dat_o;
  logic      wb_ack_o;
  logic      wb_err_o;
  logic      lci_en_i;
  logic      escalate_i;
  logic      lc_req_i;
  lc_image_t lc_data_i;
  logic      lc_ack_o;
  logic      lc_err_o;
  otp_err_e  lci_error_o;
  logic      lci_idle_o;

  // Reference fuse array
  otp_word_t model [`OTP_DEPTH];

  int        seed         = 32'hd151;
  int        cycles       = 0;
  int        err_cnt      = 0;
  int        tests_run    = 0;
  int        tests_failed = 0;
  int        prop_errs;
  int        test_start;
  logic      lc_got_err;
  logic      exp_err;
  lc_image_t img;

  otp_lc_top DUT (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic otp_word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[`OTP_WORD_W-1:0];
  endfunction

  function automatic logic in_lc(input otp_addr_t a);
    return a >= lc_first && a < otp_addr_t'(`LC_OFFSET + `LC_WORDS);
  endfunction

  // Any address outside the partition
  function automatic otp_addr_t rand_free_addr();
    logic [31:0] r;
    otp_addr_t   a;
    r = $random(seed);
    a = r[otp_addr_w-1:0];
    if (in_lc(a)) begin
      a = a + otp_addr_t'(`LC_WORDS);
    end
    return a;
  endfunction

  // Program-once rule, returns 1 when a set bit would be cleared
  function automatic logic program_model(input otp_addr_t a, input otp_word_t d);
    logic fail;
    // New word must keep every bit already set
    fail = (model[a] | d) != d;
    if (!fail) begin
      model[a] = d;
    end
    return fail;
  endfunction

  // All words are tried even after a failing one
  function automatic logic program_image(input lc_image_t im);
    logic fail;
    fail = 1'b0;
    for (int i = 0; i < `LC_WORDS; i++) begin
      if (program_model(lc_first + otp_addr_t'(i), im[i*`OTP_WORD_W +: `OTP_WORD_W])) begin
        fail = 1'b1;
      end
    end
    return fail;
  endfunction

  // Adds bits to the current partition, bit 0 always set
  function automatic lc_image_t rand_image();
    lc_image_t im;
    for (int i = 0; i < `LC_WORDS; i++) begin
      im[i*`OTP_WORD_W +: `OTP_WORD_W] = model[`LC_OFFSET + i] | rand_word() | otp_word_t'(1);
    end
    return im;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and report
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input otp_word_t got, input otp_word_t exp);
    assert (got == exp) else begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got == exp) else begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host bus
  ////////////////////////////////////////////////////////////////////////////

  // One Wishbone classic cycle, ended by ack or err
  task automatic wb_access(input logic we, input otp_addr_t a, input otp_word_t d,
                           output otp_word_t rd, output logic got_err);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = a;
    wb_dat_i = d;
    @(negedge clk_i);
    while (!(wb_ack_o || wb_err_o)) begin
      @(negedge clk_i);
    end
    assert (!(wb_ack_o && wb_err_o)) else begin
      $display("Wishbone cycle ended with ack and err together");
      err_cnt++;
    end
    rd       = wb_dat_o;
    got_err  = wb_err_o;
    // Strobe low for at least the next cycle
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic dai_program(input otp_addr_t a, input otp_word_t d);
    otp_word_t rd;
    logic      got_err;
    logic      exp_fail;
    // Partition words are refused over the host bus
    if (in_lc(a)) begin
      exp_fail = 1'b1;
    end else begin
      exp_fail = program_model(a, d);
    end
    wb_access(1'b1, a, d, rd, got_err);
    check_flag($sformatf("wb_err_o[%0d]", a), got_err, exp_fail);
  endtask

  task automatic dai_read_check(input otp_addr_t a);
    otp_word_t rd;
    logic      got_err;
    wb_access(1'b0, a, '0, rd, got_err);
    check_flag($sformatf("wb_err_o[%0d]", a), got_err, 1'b0);
    check_value($sformatf("wb_dat_o[%0d]", a), rd, model[a]);
  endtask

  // Mixed reads, additive programs and likely conflicting programs
  task automatic dai_traffic(input int n);
    logic [31:0] r;
    otp_addr_t   a;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      a = rand_free_addr();
      if (r[0]) begin
        dai_read_check(a);
      end else if (r[1]) begin
        dai_program(a, model[a] | rand_word());
      end else begin
        dai_program(a, rand_word());
      end
    end
  endtask

  task automatic read_partition();
    for (int i = 0; i < `LC_WORDS; i++) begin
      dai_read_check(lc_first + otp_addr_t'(i));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Life-cycle port and reset
  ////////////////////////////////////////////////////////////////////////////

  task automatic lc_transition(input lc_image_t im, output logic got_err);
    int waited;
    @(negedge clk_i);
    lc_req_i  = 1'b1;
    lc_data_i = im;
    waited    = 1;
    @(negedge clk_i);
    while (!lc_ack_o) begin
      @(negedge clk_i);
      waited++;
    end
    got_err  = lc_err_o;
    lc_req_i = 1'b0;
    // Three cycles per word at the least
    assert (waited >= 3 * `LC_WORDS) else begin
      $display("lc_ack_o came after %0d cycles, too early for the partition", waited);
      err_cnt++;
    end
  endtask

  // Outcome of the last transition, code settles one cycle after ack
  task automatic check_lc_result(input logic exp_fail);
    check_flag("lc_err_o", lc_got_err, exp_fail);
    @(negedge clk_i);
    check_value("lci_error_o", otp_word_t'(lci_error_o),
                otp_word_t'(exp_fail ? write_blank_error : no_error));
    if (!exp_fail) begin
      check_flag("lci_idle_o", lci_idle_o, 1'b1);
    end
  endtask

  task automatic lc_expect_no_ack(input lc_image_t im);
    logic seen;
    seen = 1'b0;
    @(negedge clk_i);
    lc_req_i  = 1'b1;
    lc_data_i = im;
    repeat (200) begin
      @(negedge clk_i);
      if (lc_ack_o) begin
        seen = 1'b1;
      end
    end
    lc_req_i = 1'b0;
    assert (!seen) else begin
      $display("lc_ack_o was raised although the controller is in its error state");
      err_cnt++;
    end
  endtask

  task automatic enable_lci();
    @(negedge clk_i);
    lci_en_i = 1'b1;
    @(negedge clk_i);
    while (!lci_idle_o) begin
      @(negedge clk_i);
    end
  endtask

  // Blank array again after reset
  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < `OTP_DEPTH; i++) begin
      model[i] = '0;
    end
  endtask

  // Controller still disabled here
  task automatic check_reset_state();
    repeat (2) @(negedge clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    check_flag("wb_err_o", wb_err_o, 1'b0);
    check_flag("lc_ack_o", lc_ack_o, 1'b0);
    check_flag("lc_err_o", lc_err_o, 1'b0);
    check_flag("lci_idle_o", lci_idle_o, 1'b0);
    check_value("lci_error_o", otp_word_t'(lci_error_o), otp_word_t'(no_error));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni     = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    lci_en_i   = 1'b0;
    escalate_i = 1'b0;
    lc_req_i   = 1'b0;
    lc_data_i  = '0;

    apply_reset();
    test_start = err_cnt;
    check_reset_state();
    report_test("reset state", test_start);

    test_start = err_cnt;
    dai_traffic(60);
    report_test("random host access", test_start);

    test_start = err_cnt;
    for (int i = 0; i < `LC_WORDS; i++) begin
      dai_program(lc_first + otp_addr_t'(i), rand_word() | otp_word_t'(1));
    end
    read_partition();
    report_test("partition refused over host bus", test_start);

    test_start = err_cnt;
    enable_lci();
    img     = rand_image();
    exp_err = program_image(img);
    lc_transition(img, lc_got_err);
    check_lc_result(exp_err);
    read_partition();
    report_test("life-cycle transition", test_start);

    // Host traffic competes with the transition for the array
    test_start = err_cnt;
    img        = rand_image();
    exp_err    = program_image(img);
    fork
      lc_transition(img, lc_got_err);
      dai_traffic(12);
    join
    check_lc_result(exp_err);
    read_partition();
    report_test("concurrent transition and host", test_start);

    // Word 1 loses bit 0, which earlier transitions set
    test_start = err_cnt;
    img        = rand_image();
    img[`OTP_WORD_W +: `OTP_WORD_W] = img[`OTP_WORD_W +: `OTP_WORD_W] & ~otp_word_t'(1);
    exp_err    = program_image(img);
    lc_transition(img, lc_got_err);
    check_lc_result(exp_err);
    read_partition();
    lc_expect_no_ack(rand_image());
    report_test("failed transition", test_start);

    test_start = err_cnt;
    @(negedge clk_i);
    lci_en_i   = 1'b0;
    escalate_i = 1'b0;
    apply_reset();
    check_reset_state();
    enable_lci();
    @(negedge clk_i);
    escalate_i = 1'b1;
    @(negedge clk_i);
    // No code was latched before the escalation
    check_value("lci_error_o", otp_word_t'(lci_error_o), otp_word_t'(fsm_state_error));
    lc_expect_no_ack(rand_image());
    report_test("escalation", test_start);

    prop_errs = DUT.u_arb.arb_props.fail_cnt + DUT.u_lci.lci_props.fail_cnt;
    $display("Tests run %0d, tests failed %0d, check errors %0d, property errors %0d",
             tests_run, tests_failed, err_cnt, prop_errs);
    if (err_cnt == 0 && prop_errs == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
